// ==== verilog/rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data and address width.
`define RV_XLEN 32

`define RV_NREGS 32

// First fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

// EBREAK ends the program.
`define RV_EBREAK 32'h0010_0073

`endif

// ==== verilog/rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_params.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t; // Data, addresses and instructions.
    typedef logic [4:0] reg_addr_t;
    typedef logic [1:0] resp_t;
    typedef logic [3:0] strb_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B // Used by LUI.
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {IFU_ISSUE, IFU_WAIT, IFU_EXEC} ifu_state_e;

    typedef enum logic [1:0] {LSU_IDLE, LSU_ADDR, LSU_DATA} lsu_state_e;

    typedef enum logic [1:0] {ARB_FREE, ARB_IFU, ARB_LSU} arb_state_e;

endpackage

`default_nettype wire

// ==== verilog/rv_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface rv_bus_if
    import rv_core_pkg::*;
();
    logic  arvalid, arready;
    word_t araddr;
    logic  rvalid, rready;
    word_t rdata;
    resp_t rresp;
    logic  awvalid, awready;
    word_t awaddr;
    logic  wvalid, wready;
    word_t wdata;
    strb_t wstrb;
    logic  bvalid, bready;
    resp_t bresp;

    modport master (
        output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
        input  arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
    );

    modport slave (
        input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
        output arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
    );
endinterface

`default_nettype wire

// ==== verilog/rv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_alu
    import rv_core_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result,
    output logic    lt
);
    // The signed compare is valid whatever op is selected.
    assign lt = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = word_t'(lt);
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_params.svh"

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  logic      wen,
    input  logic      commit,
    output word_t     rdata1,
    output word_t     rdata2
);
    word_t regs [`RV_NREGS];

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && commit && waddr != '0) begin // x0 is never written.
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_exu.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_exu
    import rv_core_pkg::*;
(
    input  word_t     inst,
    input  word_t     pc,
    input  word_t     src1,
    input  word_t     src2,
    input  word_t     alu_result,
    input  logic      alu_lt,
    input  word_t     load_data,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     alu_a,
    output word_t     alu_b,
    output alu_op_e   alu_op,
    output logic      reg_wen,
    output word_t     reg_wdata,
    output logic      mem_ren,
    output logic      mem_wen,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output word_t     next_pc,
    output logic      is_mem
);
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      pc4, target;
    logic       taken;
    wb_sel_e    wb_sel;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign pc4    = pc + word_t'(4);
    assign target = pc + ((opcode == OP_JAL) ? imm_j : imm_b); // Shared by JAL and branches.

    always_comb begin
        alu_a   = src1;
        alu_b   = imm_i;
        alu_op  = ALU_ADD;
        reg_wen = 1'b0;
        wb_sel  = WB_ALU;
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        taken   = 1'b0;
        next_pc = pc4;
        case (opcode)
            OP_IMM, OP_REG: begin
                reg_wen = 1'b1;
                if (opcode == OP_REG) begin
                    alu_b = src2;
                end
                case (funct3)
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_op = (opcode == OP_REG && inst[30]) ? ALU_SUB : ALU_ADD;
                endcase
            end
            OP_LUI: begin
                reg_wen = 1'b1;
                alu_b   = imm_u;
                alu_op  = ALU_PASS_B;
            end
            OP_AUIPC: begin
                reg_wen = 1'b1;
                alu_a   = pc;
                alu_b   = imm_u;
            end
            OP_LOAD: begin
                reg_wen = 1'b1;
                wb_sel  = WB_LOAD;
                mem_ren = 1'b1;
            end
            OP_STORE: begin
                alu_b   = imm_s;
                mem_wen = 1'b1;
            end
            OP_BRANCH: begin
                alu_b  = src2; // The ALU supplies the signed compare for BLT.
                alu_op = ALU_SLT;
                case (funct3)
                    3'b000:  taken = (src1 == src2);
                    3'b001:  taken = (src1 != src2);
                    3'b100:  taken = alu_lt;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = target;
                end
            end
            OP_JAL: begin
                reg_wen = 1'b1;
                wb_sel  = WB_PC4;
                next_pc = target;
            end
            OP_JALR: begin
                reg_wen = 1'b1;
                wb_sel  = WB_PC4;
                next_pc = alu_result & ~word_t'(1);
            end
            default: ;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_LOAD: reg_wdata = load_data;
            WB_PC4:  reg_wdata = pc4;
            default: reg_wdata = alu_result;
        endcase
    end

    assign mem_addr  = alu_result;
    assign mem_wdata = src2;
    assign is_mem    = mem_ren || mem_wen;

endmodule

`default_nettype wire

// ==== verilog/rv_ifu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_params.svh"

module rv_ifu
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  word_t next_pc,
    input  logic  is_mem,
    input  logic  mem_done,
    rv_bus_if.master bus,
    output word_t pc,
    output word_t inst,
    output logic  inst_valid,
    output logic  exec_start,
    output logic  retire
);
    ifu_state_e state;
    logic       arvalid_q;

    assign inst_valid = (state == IFU_EXEC);
    assign retire     = inst_valid && (!is_mem || mem_done);

    assign bus.arvalid = arvalid_q;
    assign bus.araddr  = pc;
    assign bus.rready  = (state == IFU_WAIT);

    // The fetch port never writes.
    assign bus.awvalid = 1'b0;
    assign bus.awaddr  = '0;
    assign bus.wvalid  = 1'b0;
    assign bus.wdata   = '0;
    assign bus.wstrb   = '0;
    assign bus.bready  = 1'b0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IFU_ISSUE;
            arvalid_q  <= 1'b0;
            exec_start <= 1'b0;
            pc         <= `RV_RESET_PC;
        end else begin
            exec_start <= 1'b0;
            case (state)
                IFU_ISSUE: begin
                    if (arvalid_q && bus.arready) begin
                        arvalid_q <= 1'b0;
                        state     <= IFU_WAIT;
                    end else begin
                        arvalid_q <= 1'b1; // Only idle here right after reset.
                    end
                end
                IFU_WAIT: begin
                    if (bus.rvalid && bus.rready) begin
                        exec_start <= 1'b1;
                        state      <= IFU_EXEC;
                    end
                end
                default: begin
                    if (retire) begin
                        pc        <= next_pc;
                        arvalid_q <= 1'b1; // Next fetch starts in the cycle after retire.
                        state     <= IFU_ISSUE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rvalid && bus.rready) begin
            inst <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_lsu
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  logic  ren,
    input  logic  wen,
    input  word_t addr,
    input  word_t wdata,
    rv_bus_if.master bus,
    output word_t rdata,
    output logic  done
);
    lsu_state_e state;
    logic       arvalid_q, awvalid_q, wvalid_q;
    logic       ar_left, aw_left, w_left;
    word_t      rdata_q;

    // Address and data come straight from decode, which holds still until retire.
    assign bus.arvalid = arvalid_q;
    assign bus.araddr  = addr;
    assign bus.awvalid = awvalid_q;
    assign bus.awaddr  = addr;
    assign bus.wvalid  = wvalid_q;
    assign bus.wdata   = wdata;
    assign bus.wstrb   = '1; // Word stores only.
    assign bus.rready  = (state == LSU_DATA) && ren;
    assign bus.bready  = (state == LSU_DATA) && !ren;

    assign done  = (bus.rvalid && bus.rready) || (bus.bvalid && bus.bready);
    assign rdata = (bus.rvalid && bus.rready) ? bus.rdata : rdata_q;

    assign ar_left = arvalid_q && !bus.arready;
    assign aw_left = awvalid_q && !bus.awready;
    assign w_left  = wvalid_q && !bus.wready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= LSU_IDLE;
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
        end else begin
            case (state)
                LSU_IDLE: begin
                    if (start && (ren || wen)) begin
                        arvalid_q <= ren;
                        awvalid_q <= wen;
                        wvalid_q  <= wen;
                        state     <= LSU_ADDR;
                    end
                end
                LSU_ADDR: begin
                    arvalid_q <= ar_left;
                    awvalid_q <= aw_left; // aw and w may complete in either order.
                    wvalid_q  <= w_left;
                    if (!ar_left && !aw_left && !w_left) begin
                        state <= LSU_DATA;
                    end
                end
                default: begin
                    if (done) begin
                        state <= LSU_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rvalid && bus.rready) begin
            rdata_q <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_bus_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_bus_arb
    import rv_core_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    rv_bus_if.slave  ifu,
    rv_bus_if.slave  lsu,
    rv_bus_if.master mem
);
    arb_state_e state;
    logic       lsu_req, lsu_sel;
    logic       r_end, b_end;

    assign lsu_req = lsu.arvalid || lsu.awvalid || lsu.wvalid;
    // A free bus goes to the LSU on a tie; otherwise the fetch side is routed.
    assign lsu_sel = (state == ARB_LSU) || (state == ARB_FREE && lsu_req);

    assign mem.arvalid = lsu_sel ? lsu.arvalid : ifu.arvalid;
    assign mem.araddr  = lsu_sel ? lsu.araddr : ifu.araddr;
    assign mem.rready  = lsu_sel ? lsu.rready : ifu.rready;
    assign mem.awvalid = lsu_sel ? lsu.awvalid : ifu.awvalid;
    assign mem.awaddr  = lsu_sel ? lsu.awaddr : ifu.awaddr;
    assign mem.wvalid  = lsu_sel ? lsu.wvalid : ifu.wvalid;
    assign mem.wdata   = lsu_sel ? lsu.wdata : ifu.wdata;
    assign mem.wstrb   = lsu_sel ? lsu.wstrb : ifu.wstrb;
    assign mem.bready  = lsu_sel ? lsu.bready : ifu.bready;

    assign lsu.arready = lsu_sel && mem.arready;
    assign lsu.rvalid  = lsu_sel && mem.rvalid;
    assign lsu.awready = lsu_sel && mem.awready;
    assign lsu.wready  = lsu_sel && mem.wready;
    assign lsu.bvalid  = lsu_sel && mem.bvalid;
    assign lsu.rdata   = mem.rdata;
    assign lsu.rresp   = mem.rresp;
    assign lsu.bresp   = mem.bresp;

    assign ifu.arready = !lsu_sel && mem.arready;
    assign ifu.rvalid  = !lsu_sel && mem.rvalid;
    assign ifu.awready = !lsu_sel && mem.awready;
    assign ifu.wready  = !lsu_sel && mem.wready;
    assign ifu.bvalid  = !lsu_sel && mem.bvalid;
    assign ifu.rdata   = mem.rdata;
    assign ifu.rresp   = mem.rresp;
    assign ifu.bresp   = mem.bresp;

    assign r_end = mem.rvalid && mem.rready;
    assign b_end = mem.bvalid && mem.bready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ARB_FREE;
        end else begin
            case (state)
                ARB_FREE: begin
                    if (lsu_req) begin
                        state <= ARB_LSU;
                    end else if (ifu.arvalid) begin
                        state <= ARB_IFU;
                    end
                end
                ARB_IFU: if (r_end) state <= ARB_FREE;
                default: if (r_end || b_end) state <= ARB_FREE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_params.svh"

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  arready,
    input  logic  rvalid,
    input  word_t rdata,
    input  resp_t rresp,
    input  logic  awready,
    input  logic  wready,
    input  logic  bvalid,
    input  resp_t bresp,
    output logic  arvalid,
    output word_t araddr,
    output logic  rready,
    output logic  awvalid,
    output word_t awaddr,
    output logic  wvalid,
    output word_t wdata,
    output strb_t wstrb,
    output logic  bready,
    output word_t pc,
    output word_t inst,
    output logic  retire,
    output logic  exit
);
    rv_bus_if ifu_bus ();
    rv_bus_if lsu_bus ();
    rv_bus_if mem_bus ();

    reg_addr_t rs1, rs2, rd;
    word_t     src1, src2, alu_a, alu_b, alu_result, reg_wdata;
    word_t     next_pc, mem_addr, mem_wdata, load_data;
    alu_op_e   alu_op;
    logic      alu_lt, reg_wen, mem_ren, mem_wen, is_mem, mem_done;
    logic      inst_valid, exec_start;

    assign exit = inst_valid && (inst == `RV_EBREAK);

    assign arvalid = mem_bus.arvalid;
    assign araddr  = mem_bus.araddr;
    assign rready  = mem_bus.rready;
    assign awvalid = mem_bus.awvalid;
    assign awaddr  = mem_bus.awaddr;
    assign wvalid  = mem_bus.wvalid;
    assign wdata   = mem_bus.wdata;
    assign wstrb   = mem_bus.wstrb;
    assign bready  = mem_bus.bready;
    assign mem_bus.arready = arready;
    assign mem_bus.rvalid  = rvalid;
    assign mem_bus.rdata   = rdata;
    assign mem_bus.rresp   = rresp;
    assign mem_bus.awready = awready;
    assign mem_bus.wready  = wready;
    assign mem_bus.bvalid  = bvalid;
    assign mem_bus.bresp   = bresp;

    rv_ifu u_ifu (
        .clk(clk), .arst_n(arst_n), .next_pc(next_pc), .is_mem(is_mem),
        .mem_done(mem_done), .bus(ifu_bus.master), .pc(pc), .inst(inst),
        .inst_valid(inst_valid), .exec_start(exec_start), .retire(retire)
    );

    rv_exu u_exu (
        .inst(inst), .pc(pc), .src1(src1), .src2(src2), .alu_result(alu_result),
        .alu_lt(alu_lt), .load_data(load_data), .rs1(rs1), .rs2(rs2), .rd(rd),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .reg_wen(reg_wen),
        .reg_wdata(reg_wdata), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .next_pc(next_pc), .is_mem(is_mem)
    );

    rv_alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .lt(alu_lt));

    rv_regfile u_regfile (
        .clk(clk), .arst_n(arst_n), .raddr1(rs1), .raddr2(rs2), .waddr(rd),
        .wdata(reg_wdata), .wen(reg_wen), .commit(retire), .rdata1(src1), .rdata2(src2)
    );

    rv_lsu u_lsu (
        .clk(clk), .arst_n(arst_n), .start(exec_start), .ren(mem_ren), .wen(mem_wen),
        .addr(mem_addr), .wdata(mem_wdata), .bus(lsu_bus.master), .rdata(load_data),
        .done(mem_done)
    );

    rv_bus_arb u_bus_arb (
        .clk(clk), .arst_n(arst_n), .ifu(ifu_bus.slave), .lsu(lsu_bus.slave),
        .mem(mem_bus.master)
    );

endmodule

`default_nettype wire

// ==== dv/rv_core_props.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_params.svh"

module rv_core_props
    import rv_core_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input logic  arvalid,
    input logic  arready,
    input word_t araddr,
    input logic  awvalid,
    input logic  awready,
    input word_t awaddr,
    input logic  wvalid,
    input logic  wready,
    input word_t wdata,
    input word_t inst,
    input logic  retire,
    input logic  exit
);
    // A raised valid holds, with its payload, until the transfer.
    ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before the ar transfer");
    aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before the aw transfer");
    w_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid or wdata changed before the w transfer");

    // Only one master owns the bus, and it never reads and writes at once.
    one_request: assert property (@(posedge clk) disable iff (!arst_n)
        !(arvalid && awvalid))
        else $error("arvalid and awvalid are high together");

    // EBREAK is a one-cycle instruction that retires as it raises exit.
    exit_on_ebreak: assert property (@(posedge clk) disable iff (!arst_n)
        exit |-> (inst == `RV_EBREAK) && retire)
        else $error("exit is high for an instruction other than EBREAK or outside retire");

endmodule

bind rv_core_top rv_core_props props0 (.*);

`default_nettype wire

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_params.svh"

module rv_core_tb
    import rv_core_pkg::*;
();
    logic  clk, arst_n;
    logic  arready, rvalid, awready, wready, bvalid;
    word_t rdata;
    resp_t rresp, bresp;
    logic  arvalid, rready, awvalid, wvalid, bready, retire, exit;
    word_t araddr, awaddr, wdata, pc, inst;
    strb_t wstrb;

    word_t       tdata [0:255]; // Image, retire count, store count, store pairs.
    word_t       mem [0:127];
    logic [15:0] lfsr;
    logic        r_busy, aw_got, w_got, b_busy, finished;
    logic [1:0]  r_wait, b_wait;
    word_t       r_addr, wr_addr, wr_data;
    word_t       cur_pc, cur_inst; // Address and word of the instruction in flight.
    word_t       exp_pc, alt_pc; // alt_pc differs only after a branch.
    logic        any_pc, fetch_next;
    int          retire_cnt, n_aw, n_w;

    rv_core_top dut0 (.*);

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch %s got %h expected %h", name, actual, expected));
        end
    endtask

    // Next fetch address by the ISA rule, from the instruction in the memory copy.
    task automatic predict_next_pc(input word_t addr);
        word_t ins, imm_b, imm_j;
        ins    = mem[addr[8:2]];
        imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        exp_pc = addr + 32'd4;
        alt_pc = exp_pc;
        any_pc = (ins[6:0] == 7'b1100111); // JALR target depends on a register.
        if (ins[6:0] == 7'b1100011) begin
            alt_pc = addr + imm_b;
        end
        if (ins[6:0] == 7'b1101111) begin
            exp_pc = addr + imm_j;
            alt_pc = exp_pc;
        end
        fetch_next = (ins[6:0] != 7'b0000011); // A load reads once more before the fetch.
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // The memory model observes transfers at the edge and drives new inputs 1 ns later.
    always @(posedge clk) begin
        if (arst_n) begin
            if (arvalid && arready) begin
                if (!fetch_next) begin
                    fetch_next = 1'b1;
                end else begin
                    if (any_pc) begin
                        check_value("araddr[1:0]", word_t'(araddr[1:0]), 32'h0);
                    end else begin
                        check_value("araddr", araddr, (araddr == alt_pc) ? alt_pc : exp_pc);
                    end
                    predict_next_pc(araddr);
                    cur_pc   = araddr;
                    cur_inst = mem[araddr[8:2]];
                end
                r_busy = 1'b1;
                r_addr = araddr;
                r_wait = {take_bit(), take_bit()};
            end
            if (rvalid && rready) begin
                r_busy = 1'b0;
            end
            if (awvalid && awready) begin
                if (n_aw >= tdata[129]) begin
                    abort_run("The core wrote an address more often than the program stores.");
                end else begin
                    check_value("awaddr", awaddr, tdata[130 + 2 * n_aw]);
                    n_aw++;
                    aw_got  = 1'b1;
                    wr_addr = awaddr;
                end
            end
            if (wvalid && wready) begin
                if (n_w >= tdata[129]) begin
                    abort_run("The core wrote data more often than the program stores.");
                end else begin
                    check_value("wdata", wdata, tdata[131 + 2 * n_w]);
                    check_value("wstrb", word_t'(wstrb), 32'hF);
                    n_w++;
                    w_got   = 1'b1;
                    wr_data = wdata;
                end
            end
            if (bvalid && bready) begin
                b_busy = 1'b0;
            end
            if (retire) begin
                retire_cnt++;
                check_value("pc", pc, cur_pc);
                check_value("inst", inst, cur_inst);
                check_value("exit", word_t'(exit), word_t'(cur_inst == `RV_EBREAK));
            end
            if (exit) begin
                finished = 1'b1;
            end
        end
        #1;
        if (aw_got && w_got) begin
            mem[wr_addr[8:2]] = wr_data;
            aw_got = 1'b0;
            w_got  = 1'b0;
            b_busy = 1'b1;
            b_wait = {take_bit(), take_bit()};
        end
        if (r_busy && r_wait != 2'd0) begin
            r_wait = r_wait - 2'd1;
        end
        if (b_busy && b_wait != 2'd0) begin
            b_wait = b_wait - 2'd1;
        end
        rvalid  = r_busy && (r_wait == 2'd0);
        rdata   = r_busy ? mem[r_addr[8:2]] : '0;
        bvalid  = b_busy && (b_wait == 2'd0);
        arready = !r_busy && take_bit();
        awready = !aw_got && take_bit();
        wready  = !w_got && take_bit();
    end

    initial begin
        #1;
        repeat (400 * tdata[128] + 8) @(posedge clk);
        abort_run("Timeout: the program did not reach EBREAK in the allowed cycles.");
    end

    initial begin
        arst_n     = 1'b0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = '0;
        rresp      = '0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        bresp      = '0;
        lfsr       = 16'd52;
        r_busy     = 1'b0;
        aw_got     = 1'b0;
        w_got      = 1'b0;
        b_busy     = 1'b0;
        r_wait     = 2'd0;
        b_wait     = 2'd0;
        finished   = 1'b0;
        retire_cnt = 0;
        n_aw       = 0;
        n_w        = 0;
        cur_pc     = '0;
        cur_inst   = '0;
        exp_pc     = `RV_RESET_PC;
        alt_pc     = `RV_RESET_PC;
        any_pc     = 1'b0;
        fetch_next = 1'b1;
        $readmemh("dv/rv_core_testdata.hex", tdata);
        for (int i = 0; i < 128; i++) begin
            mem[i] = tdata[i];
        end
        repeat (4) @(posedge clk);
        check_value("{arvalid,awvalid,wvalid,rready,bready,retire,exit}",
                    word_t'({arvalid, awvalid, wvalid, rready, bready, retire, exit}), 32'h0);
        #1 arst_n = 1'b1;
        wait (finished);
        check_value("retire count", retire_cnt, tdata[128]);
        check_value("store address count", n_aw, tdata[129]);
        check_value("store data count", n_w, tdata[129]);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core_top.f ====
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/rv_bus_if.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_exu.sv
verilog/rv_ifu.sv
verilog/rv_lsu.sv
verilog/rv_bus_arb.sv
verilog/rv_core_top.sv
dv/rv_core_props.sv
dv/rv_core_tb.sv

// ==== dv/rv_core_testdata.hex ====
// Words 0-127: program and data image, four words a line starting at the byte address shown.
// Word 128: retire count. Word 129: store count. Then one store per line, address and data.
@00
00500093 FFD00113 10000513 002081B3  // 0x00 addi, addi, addi, add
40208233 00352023 00452223 123452B7  // 0x10 sub, sw, sw, lui
00001317 00552423 00652623 0F017393  // 0x20 auipc, sw, sw, andi
00F3E413 FFF44493 00112593 0064F633  // 0x30 ori, xori, slti, and
00B666B3 0086C733 001127B3 0020A833  // 0x40 or, xor, slt, slt
40F808B3 00E52823 01152A23 00052903  // 0x50 sub, sw, sw, lw
00852983 01390A33 01452C23 0F052A83  // 0x60 lw, add, sw, lw
014ACB33 01652E23 00208463 00100B93  // 0x70 xor, sw, beq not taken, marker
00209463 010B8B93 00114463 020B8B93  // 0x80 bne taken, skipped, blt taken, skipped
0020C463 002B8B93 00390463 040B8B93  // 0x90 blt not taken, marker, beq taken, skipped
00391463 004B8B93 00800C6F 080B8B93  // 0xA0 bne not taken, marker, jal, skipped
0C000C93 005C8D67 100B8B93 200B8B93  // 0xB0 addi, jalr to 0xC4, skipped, skipped
400B8B93 03752023 03852223 03A52423  // 0xC0 skipped, sw marker, sw jal link, sw jalr link
00100073                             // 0xD0 ebreak
@7C
13572468                             // 0x1F0 data word loaded by the program
@80
0000002E 0000000B
00000100 00000002
00000104 00000008
00000108 12345000
0000010C 00001020
00000110 000010FE
00000114 FFFFFFFF
00000118 12345002
0000011C 0163746A
00000120 00000007
00000124 000000AC
00000128 000000B8
